//--- build.f
rs_pkg.sv
rs_dispatch.sv
rs_entry.sv
rs_issue_select.sv
rs_top.sv
rs_assert.sv
tb_rs.sv

//--- run.sh
#!/bin/sh
# build the reservation station testbench with Verilator and run it
# success is decided by the pass line in the simulation output

verilator --binary --assert --top-module tb_rs -f build.f -o tb_rs_sim \
    && ./obj_dir/tb_rs_sim | grep "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

//--- tb_rs.sv
//************************************************************
// testbench for the two-way reservation station
// results on the cdb are a fixed function of the tag, so the
// expected issue values follow from the dispatched operation
// rob ids are unique within a phase; each phase drains fully
//************************************************************
`default_nettype none

module tb_rs;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 2000;

    logic                                   clock;
    logic                                   reset;
    logic [rs_pkg::ways-1:0]                dispatch_valid;
    rs_pkg::rs_op_t [rs_pkg::ways-1:0]      dispatch_op;
    logic                                   dispatch_ready;
    rs_pkg::cdb_t [rs_pkg::ways-1:0]        cdb;
    logic [rs_pkg::ways-1:0]                port_busy;
    logic [rs_pkg::ways-1:0]                issue_valid;
    rs_pkg::issue_t [rs_pkg::ways-1:0]      issue_op;

    rs_pkg::issue_t                 expected_table [2**rs_pkg::rob_width];
    bit                             pending [2**rs_pkg::rob_width];
    bit                             a_wait [2**rs_pkg::rob_width];
    bit                             b_wait [2**rs_pkg::rob_width];
    logic [rs_pkg::tag_width-1:0]   a_tag [2**rs_pkg::rob_width];
    logic [rs_pkg::tag_width-1:0]   b_tag [2**rs_pkg::rob_width];
    bit                             seen [2**rs_pkg::tag_width];
    int                             error_count;
    int                             pending_count;
    int                             rr_tag;
    int                             cdb_mode;
    int                             busy_mode;

    rs_top rs_top_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .port_busy      (port_busy),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [15:0] value_of_tag(logic [rs_pkg::tag_width-1:0] tag);
        return (16'(tag) * 16'd2731) ^ 16'h5a3c;
    endfunction

    // a waiting operand gets the broadcast value of its tag
    function automatic rs_pkg::issue_t expected_issue(rs_pkg::rs_op_t op);
        rs_pkg::issue_t result;
        result.rob_id  = op.rob_id;
        result.opcode  = op.opcode;
        result.a_value = op.src_a.ready ? op.src_a.value : value_of_tag(op.src_a.tag);
        result.b_value = op.src_b.ready ? op.src_b.value : value_of_tag(op.src_b.tag);
        return result;
    endfunction

    // mode 0 all ready, 1 random, 2 one operand waits on tag = rob id
    function automatic rs_pkg::rs_op_t make_op(int rob, int op_mode);
        rs_pkg::rs_op_t op;
        op.rob_id      = 4'(rob);
        op.opcode      = rs_pkg::alu_op_e'($urandom_range(0, 3));
        op.src_a.tag   = 5'($urandom_range(0, 31));
        op.src_b.tag   = 5'($urandom_range(0, 31));
        op.src_a.value = 16'($urandom);
        op.src_b.value = 16'($urandom);
        op.src_a.ready = 1'((op_mode == 0) || (op_mode == 1 && $urandom_range(0, 1) == 1));
        op.src_b.ready = 1'((op_mode == 0) || (op_mode == 1 && $urandom_range(0, 1) == 1));
        if (op_mode == 2) begin
            op.src_a.ready = 1'(rob % 2);
            op.src_b.ready = 1'(1 - rob % 2);
            op.src_a.tag   = 5'(rob);
            op.src_b.tag   = 5'(rob);
        end
        return op;
    endfunction

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic record(rs_pkg::rs_op_t op);
        expected_table[op.rob_id] = expected_issue(op);
        a_wait[op.rob_id]         = !op.src_a.ready;
        b_wait[op.rob_id]         = !op.src_b.ready;
        a_tag[op.rob_id]          = op.src_a.tag;
        b_tag[op.rob_id]          = op.src_b.tag;
        pending[op.rob_id]        = 1'b1;
        pending_count++;
    endtask

    // cdb mode 0 idle, 1 round robin, 2 bypass of the offered ops
    task automatic drive_side_inputs(int cycle);
        for (int w = 0; w < rs_pkg::ways; w++) begin
            cdb[w] = '0;
            if (cdb_mode == 1) begin
                cdb[w].valid = 1'($urandom_range(0, 1));
                cdb[w].tag   = 5'(rr_tag + 16 * w);
            end else if (cdb_mode == 2 && dispatch_valid[w]) begin
                cdb[w].valid = 1'b1;
                cdb[w].tag   = 5'(dispatch_op[w].rob_id);
            end
            cdb[w].value = value_of_tag(cdb[w].tag);
            if (cdb[w].valid) begin
                seen[cdb[w].tag] = 1'b1;
            end
        end
        rr_tag = (rr_tag + 1) % 16;
        if (busy_mode == 1) begin
            // port 0 frees a few cycles before port 1
            port_busy = (cycle < 30) ? 2'b11 : (cycle < 34) ? 2'b10 : 2'b00;
        end else if (busy_mode == 2) begin
            port_busy = 2'($urandom_range(0, 3));
        end else begin
            port_busy = '0;
        end
    endtask

    task automatic dispatch_group(int n_pairs, int op_mode);
        int  sent;
        int  cycle;
        bit  accepted;
        sent           = 0;
        cycle          = 0;
        dispatch_valid = '1;
        dispatch_op[0] = make_op(0, op_mode);
        dispatch_op[1] = make_op(1, op_mode);
        while (sent < n_pairs && cycle < timeout_cycles) begin
            drive_side_inputs(cycle);
            @(negedge clock);
            check("dispatch_ready", 64'(pending_count <= rs_pkg::rs_size - rs_pkg::ways),
                  64'(dispatch_ready));
            accepted = dispatch_ready;
            if (accepted) begin
                record(dispatch_op[0]);
                record(dispatch_op[1]);
                sent++;
            end
            @(posedge clock);
            #1;
            cycle++;
            if (accepted && sent < n_pairs) begin
                dispatch_op[0] = make_op(2 * sent, op_mode);
                dispatch_op[1] = make_op(2 * sent + 1, op_mode);
            end
        end
        if (sent < n_pairs) begin
            error_count++;
            $display("dispatch stalled: only %0d of %0d pairs accepted", sent, n_pairs);
        end
        dispatch_valid = '0;
    endtask

    task automatic drain(string phase);
        int cycle;
        cycle = 0;
        while (pending_count > 0 && cycle < timeout_cycles) begin
            drive_side_inputs(cycle);
            @(posedge clock);
            #1;
            cycle++;
        end
        if (pending_count > 0) begin
            error_count++;
            $display("%s: %0d operations never issued", phase, pending_count);
        end
    endtask

    always @(posedge clock) begin : compare_issues
        logic [rs_pkg::rob_width-1:0] rob;
        if (!reset) begin
            for (int p = 0; p < rs_pkg::ways; p++) begin
                if (issue_valid[p]) begin
                    rob = issue_op[p].rob_id;
                    if (!pending[rob]) begin
                        error_count++;
                        $display("rob id %0d issued without a pending operation", rob);
                    end else begin
                        check("issue_op", 64'(expected_table[rob]), 64'(issue_op[p]));
                        check("issue on busy port", 64'(1'b0), 64'(port_busy[p]));
                        if (a_wait[rob]) begin
                            check("tag a seen before issue", 64'(1'b1), 64'(seen[a_tag[rob]]));
                        end
                        if (b_wait[rob]) begin
                            check("tag b seen before issue", 64'(1'b1), 64'(seen[b_tag[rob]]));
                        end
                        pending[rob] = 1'b0;
                        pending_count--;
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(29));
        reset          = 1'b1;
        dispatch_valid = '0;
        dispatch_op    = '0;
        cdb            = '0;
        port_busy      = '0;
        error_count    = 0;
        pending_count  = 0;
        rr_tag         = 0;
        cdb_mode       = 0;
        busy_mode      = 0;
        foreach (pending[i]) pending[i] = 1'b0;
        foreach (seen[i]) seen[i] = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        check("dispatch_ready after reset", 64'(1'b1), 64'(dispatch_ready));

        dispatch_group(4, 0);
        drain("ready operands");

        // tags stay silent during dispatch, then the cdb wakes them
        foreach (seen[i]) seen[i] = 1'b0;
        dispatch_group(4, 1);
        cdb_mode = 1;
        drain("tag wakeup");

        foreach (seen[i]) seen[i] = 1'b0;
        cdb_mode = 2;
        dispatch_group(4, 2);
        cdb_mode = 0;
        drain("dispatch bypass");

        busy_mode = 1;
        dispatch_group(6, 0);
        drain("full window");

        foreach (seen[i]) seen[i] = 1'b0;
        busy_mode = 2;
        cdb_mode  = 1;
        dispatch_group(8, 1);
        drain("busy ports");

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rs_assert.sv
//************************************************************
// handshake and issue checks, bound into rs_top
// stability of dispatch inputs is only required while the
// window holds them back
//************************************************************
`default_nettype none

module rs_assert (
    input wire                                      clock,
    input wire                                      reset,
    input wire [rs_pkg::ways-1:0]                   dispatch_valid,
    input wire rs_pkg::rs_op_t [rs_pkg::ways-1:0]   dispatch_op,
    input wire                                      dispatch_ready,
    input wire [rs_pkg::ways-1:0]                   port_busy,
    input wire [rs_pkg::ways-1:0]                   issue_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    no_issue_on_busy: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & port_busy) == '0)
        else $error("issue_valid on a busy port");

    held_op_stable: assert property (@(posedge clock) disable iff (reset)
        (dispatch_valid != '0 && !dispatch_ready) |=> $stable(dispatch_op))
        else $error("dispatch_op changed while held back");

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> issue_valid == '0)
        else $error("issue_valid high right after reset");

endmodule

bind rs_top rs_assert rs_assert_inst (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_ready (dispatch_ready),
    .port_busy      (port_busy),
    .issue_valid    (issue_valid)
);

`default_nettype wire

//--- rs_top.sv
//************************************************************
// two-way reservation station with cdb wakeup
// dispatch to earliest issue is one cycle; a cdb tag seen
// in the accept cycle is captured by the dispatch bypass
// the source must hold dispatch inputs while ready is low
//************************************************************
`default_nettype none

module rs_top (
    input  wire                                       clock,
    input  wire                                       reset,
    input  wire [rs_pkg::ways-1:0]                    dispatch_valid,
    input  wire rs_pkg::rs_op_t [rs_pkg::ways-1:0]    dispatch_op,
    output logic                                      dispatch_ready,
    input  wire rs_pkg::cdb_t [rs_pkg::ways-1:0]      cdb,
    input  wire [rs_pkg::ways-1:0]                    port_busy,
    output logic [rs_pkg::ways-1:0]                   issue_valid,
    output rs_pkg::issue_t [rs_pkg::ways-1:0]         issue_op
);

    logic [rs_pkg::rs_size-1:0]               load;
    logic [rs_pkg::rs_size-1:0]               entry_free;
    logic [rs_pkg::rs_size-1:0]               entry_ready;
    logic [rs_pkg::rs_size-1:0]               grant;
    rs_pkg::rs_op_t [rs_pkg::rs_size-1:0]     load_op;
    rs_pkg::rs_op_t [rs_pkg::rs_size-1:0]     held_op;

    rs_dispatch dispatch_stage (
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .cdb            (cdb),
        .entry_free     (entry_free),
        .dispatch_ready (dispatch_ready),
        .load           (load),
        .load_op        (load_op)
    );

    for (genvar i = 0; i < rs_pkg::rs_size; i++) begin : entries
        rs_entry entry_inst (
            .clock   (clock),
            .reset   (reset),
            .load    (load[i]),
            .load_op (load_op[i]),
            .cdb     (cdb),
            .grant   (grant[i]),
            .free    (entry_free[i]),
            .ready   (entry_ready[i]),
            .held_op (held_op[i])
        );
    end

    rs_issue_select select_stage (
        .ready       (entry_ready),
        .held_op     (held_op),
        .port_busy   (port_busy),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_op    (issue_op)
    );

endmodule

`default_nettype wire

//--- rs_issue_select.sv
//************************************************************
// issue select, purely combinational
// lowest ready entry index goes first, onto the lowest port
// that is not busy; a ready entry with no port just waits
// a grant frees its entry at the next edge
//************************************************************
`default_nettype none

module rs_issue_select (
    input  wire [rs_pkg::rs_size-1:0]                   ready,
    input  wire rs_pkg::rs_op_t [rs_pkg::rs_size-1:0]   held_op,
    input  wire [rs_pkg::ways-1:0]                      port_busy,
    output logic [rs_pkg::rs_size-1:0]                  grant,
    output logic [rs_pkg::ways-1:0]                     issue_valid,
    output rs_pkg::issue_t [rs_pkg::ways-1:0]           issue_op
);

    logic [rs_pkg::ways-1:0]    port_taken;
    logic                       placed;

    function automatic rs_pkg::issue_t to_issue(rs_pkg::rs_op_t op);
        rs_pkg::issue_t result;
        result.rob_id  = op.rob_id;
        result.opcode  = op.opcode;
        result.a_value = op.src_a.value;
        result.b_value = op.src_b.value;
        return result;
    endfunction

    // busy ports start out taken
    always_comb begin
        grant       = '0;
        issue_valid = '0;
        issue_op    = '0;
        port_taken  = port_busy;
        placed      = 1'b0;
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            placed = 1'b0;
            if (ready[i]) begin
                for (int p = 0; p < rs_pkg::ways; p++) begin
                    if (!placed && !port_taken[p]) begin
                        grant[i]       = 1'b1;
                        issue_valid[p] = 1'b1;
                        issue_op[p]    = to_issue(held_op[i]);
                        port_taken[p]  = 1'b1;
                        placed         = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rs_entry.sv
//************************************************************
// one reservation station line
// load must only reach a free line, so load and grant never
// meet; a cdb match sets the operand ready at the next edge
// payload is not reset, only the occupied flag
//************************************************************
`default_nettype none

module rs_entry (
    input  wire                                   clock,
    input  wire                                   reset,
    input  wire                                   load,
    input  wire rs_pkg::rs_op_t                   load_op,
    input  wire rs_pkg::cdb_t [rs_pkg::ways-1:0]  cdb,
    input  wire                                   grant,
    output logic                                  free,
    output logic                                  ready,
    output rs_pkg::rs_op_t                        held_op
);

    logic               occupied;
    rs_pkg::rs_op_t     op_q;
    rs_pkg::operand_t   next_a;
    rs_pkg::operand_t   next_b;

    // wakeup from the result buses
    always_comb begin
        next_a = rs_pkg::snoop_operand(op_q.src_a, cdb);
        next_b = rs_pkg::snoop_operand(op_q.src_b, cdb);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied <= 1'b0;
        end else if (load) begin
            occupied <= 1'b1;
        end else if (grant) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            op_q <= load_op;
        end else begin
            op_q.src_a <= next_a;
            op_q.src_b <= next_b;
        end
    end

    assign free    = !occupied;
    // only the stored ready bits count, so wakeup costs one cycle
    assign ready   = occupied && op_q.src_a.ready && op_q.src_b.ready;
    assign held_op = op_q;

endmodule

`default_nettype wire

//--- rs_dispatch.sv
//************************************************************
// dispatch stage, purely combinational
// ready needs room for a full group of ways, counted from the
// current free flags; entries granted this cycle do not count
// valid ways fill the lowest free entries in way order
//************************************************************
`default_nettype none

module rs_dispatch (
    input  wire [rs_pkg::ways-1:0]                    dispatch_valid,
    input  wire rs_pkg::rs_op_t [rs_pkg::ways-1:0]    dispatch_op,
    input  wire rs_pkg::cdb_t [rs_pkg::ways-1:0]      cdb,
    input  wire [rs_pkg::rs_size-1:0]                 entry_free,
    output logic                                      dispatch_ready,
    output logic [rs_pkg::rs_size-1:0]                load,
    output rs_pkg::rs_op_t [rs_pkg::rs_size-1:0]      load_op
);

    logic [rs_pkg::slot_width:0]               free_count;
    rs_pkg::rs_op_t [rs_pkg::ways-1:0]         bypassed;
    logic [rs_pkg::ways-1:0]                   placed;
    logic                                      found;

    // results broadcast in the accept cycle would otherwise be missed
    always_comb begin
        for (int w = 0; w < rs_pkg::ways; w++) begin
            bypassed[w]       = dispatch_op[w];
            bypassed[w].src_a = rs_pkg::snoop_operand(dispatch_op[w].src_a, cdb);
            bypassed[w].src_b = rs_pkg::snoop_operand(dispatch_op[w].src_b, cdb);
        end
    end

    always_comb begin
        free_count = '0;
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            if (entry_free[i]) begin
                free_count = free_count + 1'b1;
            end
        end
    end

    assign dispatch_ready = (free_count >= (rs_pkg::slot_width + 1)'(rs_pkg::ways));

    // walk free entries upward, handing each the next unplaced valid way
    always_comb begin
        load    = '0;
        load_op = '0;
        placed  = '0;
        found   = 1'b0;
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            found = 1'b0;
            if (entry_free[i] && dispatch_ready) begin
                for (int w = 0; w < rs_pkg::ways; w++) begin
                    if (!found && dispatch_valid[w] && !placed[w]) begin
                        load[i]    = 1'b1;
                        load_op[i] = bypassed[w];
                        placed[w]  = 1'b1;
                        found      = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rs_pkg.sv
//************************************************************
// shared widths, sizes and types of the reservation station
// an operand value is don't-care while its ready bit is low
// valid cdb lanes never carry the same tag in one cycle
//************************************************************
`default_nettype none

package rs_pkg;

    localparam int data_width = 16;
    localparam int tag_width  = 5;
    localparam int rob_width  = 4;
    localparam int ways       = 2;
    localparam int rs_size    = 8;
    localparam int slot_width = $clog2(rs_size);

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_and = 2'd2,
        op_xor = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic                  ready;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] value;
    } operand_t;

    typedef struct packed {
        logic [rob_width-1:0] rob_id;
        alu_op_e              opcode;
        operand_t             src_a;
        operand_t             src_b;
    } rs_op_t;

    typedef struct packed {
        logic                  valid;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic [rob_width-1:0]  rob_id;
        alu_op_e               opcode;
        logic [data_width-1:0] a_value;
        logic [data_width-1:0] b_value;
    } issue_t;

    // a waiting operand takes the value of a matching broadcast
    function automatic operand_t snoop_operand(operand_t src, cdb_t [ways-1:0] lanes);
        operand_t result;
        result = src;
        for (int i = 0; i < ways; i++) begin
            if (!src.ready && lanes[i].valid && lanes[i].tag == src.tag) begin
                result.ready = 1'b1;
                result.value = lanes[i].value;
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire
